/* tb.f */
+incdir+tests
source/fpMulPkg.sv
source/fpMulCtrl.sv
source/fpMulStepCounter.sv
source/fpMulCore.sv
source/fpNormalize32.sv
source/fpRound32.sv
source/fpMul32.sv
tests/fpMulTb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for a pass
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary -j 0 \
	--timescale 1ns/100ps \
	--top-module fpMulTb \
	-f tb.f \
	-o fpMulSim

./obj_dir/fpMulSim > "$LOG" 2>&1
cat "$LOG"

if grep -qx "Verification passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tests/fpMulVectors.svh */
/*
 * Directed operand pairs for the binary32 multiply testbench.
 * Each row holds operand a, operand b, the expected result word and the
 * expected flags as {underflow, overflow, inexact, invalid}.
 * Included inside the testbench module and applied in a loop.
 */
`ifndef FP_MUL_VECTORS_SVH
`define FP_MUL_VECTORS_SVH

typedef struct packed {
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic [3:0] flags;
} vecRowS;

localparam int VEC_COUNT = 35;

localparam vecRowS VEC_TABLE [VEC_COUNT] = '{
	// exact normal products, two of them need the exponent increment
	{32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0000, 4'b0000},
	{32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000, 4'b0000},
	{32'h4000_0000, 32'hC040_0000, 32'hC0C0_0000, 4'b0000},
	{32'hBFC0_0000, 32'hBFC0_0000, 32'h4010_0000, 4'b0000},
	{32'h3F00_0000, 32'h3E80_0000, 32'h3E00_0000, 4'b0000},
	{32'h7F7F_FFFF, 32'h3F80_0000, 32'h7F7F_FFFF, 4'b0000},
	// tie with an odd kept lsb goes up, with an even one it stays
	{32'h3F80_0001, 32'h3FC0_0000, 32'h3FC0_0002, 4'b0010},
	{32'h3F80_0003, 32'h3FC0_0000, 32'h3FC0_0004, 4'b0010},
	// below half, above half, and below half in the [2,4) range
	{32'h3F80_0001, 32'h3F80_0001, 32'h3F80_0002, 4'b0010},
	{32'h3F80_0001, 32'h3FC0_0001, 32'h3FC0_0003, 4'b0010},
	{32'h3FFF_FFFF, 32'h3FFF_FFFF, 32'h407F_FFFE, 4'b0010},
	// rounding carries all the way into the exponent
	{32'h3FFF_FFFE, 32'h3F80_0001, 32'h4000_0000, 4'b0010},
	// overflow, the last one only through the rounding carry
	{32'h7F00_0000, 32'h4000_0000, 32'h7F80_0000, 4'b0110},
	{32'hFF00_0000, 32'h7F00_0000, 32'hFF80_0000, 4'b0110},
	{32'h7F7F_FFFE, 32'h3F80_0001, 32'h7F80_0000, 4'b0110},
	// exact denormal, then denormals that round down and up
	{32'h0D80_0000, 32'h3080_0000, 32'h0008_0000, 4'b0000},
	{32'h0D80_0001, 32'h3080_0000, 32'h0008_0000, 4'b1010},
	{32'h0DE0_0000, 32'h2680_0000, 32'h0000_0001, 4'b1010},
	// half of the smallest denormal ties to zero
	{32'h0D80_0000, 32'h2680_0000, 32'h0000_0000, 4'b1010},
	{32'h0D80_0000, 32'h0D80_0000, 32'h0000_0000, 4'b1010},
	{32'h8D80_0000, 32'h0D80_0000, 32'h8000_0000, 4'b1010},
	// exponent sum of zero lifted back to normal by the increment
	{32'h2040_0000, 32'h1FC0_0000, 32'h0090_0000, 4'b0000},
	// zeros, a denormal operand counts as zero
	{32'h0000_0000, 32'h40A0_0000, 32'h0000_0000, 4'b0000},
	{32'h8000_0000, 32'h40A0_0000, 32'h8000_0000, 4'b0000},
	{32'h4040_0000, 32'h8000_0000, 32'h8000_0000, 4'b0000},
	{32'h0000_0001, 32'h3F80_0000, 32'h0000_0000, 4'b0000},
	// infinities
	{32'h7F80_0000, 32'h4000_0000, 32'h7F80_0000, 4'b0000},
	{32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000, 4'b0000},
	{32'hFF80_0000, 32'hFF80_0000, 32'h7F80_0000, 4'b0000},
	{32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000, 4'b0001},
	{32'h8000_0000, 32'hFF80_0000, 32'h7FC0_0000, 4'b0001},
	// NaN operands give the default quiet NaN
	{32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000, 4'b0000},
	{32'h7F80_0001, 32'h4000_0000, 32'h7FC0_0000, 4'b0000},
	{32'h3F80_0000, 32'hFFC0_0000, 32'h7FC0_0000, 4'b0000},
	{32'h7FC0_0000, 32'h0000_0000, 32'h7FC0_0000, 4'b0001}
};

`endif

/* tests/fpMulTb.sv */
/*
 * Testbench for the binary32 multiply unit.
 * Checks the idle state after reset, applies the directed table, checks
 * that a start while busy is ignored, then runs LFSR-drawn normal pairs
 * against an integer model of round-to-nearest-even.
 */
`timescale 1ns/100ps
`default_nettype none

module fpMulTb;

	localparam int N_RAND = 200;
	localparam int LATENCY = 28;
	localparam int DONE_WAIT = 40;
	localparam logic [31:0] SEED = 32'h7ecb_2f7c;

	`include "fpMulVectors.svh"

	// thirty cycles per operation plus the busy test and reset
	localparam int CYCLE_LIMIT = (VEC_COUNT + N_RAND + 4) * 30 + 200;

	logic clk = 1'b0;
	logic rstN_i;
	logic start_i;
	logic [31:0] a_i;
	logic [31:0] b_i;
	logic busy_o;
	logic done_o;
	logic [31:0] result_o;
	logic underflow_o;
	logic overflow_o;
	logic inexact_o;
	logic invalid_o;

	int errors = 0;
	int checks = 0;
	int cycleCount = 0;
	logic [31:0] lfsr;
	vecRowS row;
	logic [31:0] res;
	logic [3:0] flags;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [32:0] model;

	fpMul32 dut0 (
		.clk(clk), .rstN_i(rstN_i), .start_i(start_i), .a_i(a_i), .b_i(b_i),
		.busy_o(busy_o), .done_o(done_o), .result_o(result_o),
		.underflow_o(underflow_o), .overflow_o(overflow_o), .inexact_o(inexact_o),
		.invalid_o(invalid_o)
	);

	always #4 clk = ~clk;

	// watchdog on the whole run
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("simulation stopped after %0d cycles without finishing", cycleCount);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic compareValue(input string what, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, want);
		end
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// exponent field kept in 96..159 so every product stays normal
	function automatic logic [31:0] randomOperand();
		logic [31:0] s;
		logic [31:0] e;
		logic [31:0] f;
		s = takeBits(1);
		e = takeBits(6);
		f = takeBits(23);
		return {s[0], 8'(e[5:0]) + 8'd96, f[22:0]};
	endfunction

	// exact 48-bit product rounded to 24 bits, ties to even
	// returns the inexact bit above the result word
	function automatic logic [32:0] expectedProduct(input logic [31:0] a, input logic [31:0] b);
		logic [47:0] p;
		logic [23:0] keep;
		logic [23:0] rest;
		logic [24:0] sum;
		logic up;
		int e;
		p = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
		e = int'(a[30:23]) + int'(b[30:23]) - 127;
		if (p[47]) begin
			e = e + 1;
			keep = p[47:24];
			rest = p[23:0];
		end else begin
			keep = p[46:23];
			rest = {p[22:0], 1'b0};
		end
		// the top bit of rest is the half point
		up = (rest > 24'h80_0000) || (rest == 24'h80_0000 && keep[0]);
		sum = {1'b0, keep} + 25'(up);
		if (sum[24]) begin
			e = e + 1;
			sum = sum >> 1;
		end
		return {rest != '0, a[31] ^ b[31], e[7:0], sum[22:0]};
	endfunction

	// starts at a falling edge, waits for done and checks latency and busy
	// pokeAt names a cycle where a second start is pulsed, zero for none
	task automatic runMultiply(input logic [31:0] a, input logic [31:0] b, input int pokeAt,
			output logic [31:0] got, output logic [3:0] gotFlags);
		int cycles;
		compareValue("busy_o before start", 32'(busy_o), 32'd0);
		a_i = a;
		b_i = b;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		cycles = 1;
		while (!done_o && cycles < DONE_WAIT) begin
			compareValue("busy_o during operation", 32'(busy_o), 32'd1);
			if (cycles == pokeAt) begin
				a_i = 32'h4000_0000;
				b_i = 32'h4040_0000;
				start_i = 1'b1;
			end
			@(negedge clk);
			start_i = 1'b0;
			cycles++;
		end
		if (!done_o) begin
			errors++;
			$display("no done pulse within %0d cycles of the start", DONE_WAIT);
		end
		compareValue("cycles from start to done", 32'(cycles), 32'(LATENCY));
		got = result_o;
		gotFlags = {underflow_o, overflow_o, inexact_o, invalid_o};
		@(negedge clk);
		compareValue("done_o after its pulse", 32'(done_o), 32'd0);
	endtask

	initial begin
		rstN_i = 1'b0;
		start_i = 1'b0;
		a_i = '0;
		b_i = '0;
		lfsr = SEED;
		repeat (10) @(negedge clk);
		rstN_i = 1'b1;
		@(negedge clk);

		// --------------------
		// idle after reset
		// --------------------
		compareValue("busy_o after reset", 32'(busy_o), 32'd0);
		compareValue("done_o after reset", 32'(done_o), 32'd0);
		compareValue("result_o after reset", result_o, 32'd0);
		compareValue("flags after reset",
			32'({underflow_o, overflow_o, inexact_o, invalid_o}), 32'd0);

		// --------------------
		// directed table
		// --------------------
		for (int i = 0; i < VEC_COUNT; i++) begin
			row = VEC_TABLE[i];
			runMultiply(row.a, row.b, 0, res, flags);
			compareValue($sformatf("row %0d result", i), res, row.res);
			compareValue($sformatf("row %0d flags", i), 32'(flags), 32'(row.flags));
		end

		// a second start in the middle must not disturb 1.5 times 1.5
		runMultiply(32'h3FC0_0000, 32'h3FC0_0000, 10, res, flags);
		compareValue("result with start while busy", res, 32'h4010_0000);
		compareValue("flags with start while busy", 32'(flags), 32'd0);
		repeat (DONE_WAIT) begin
			compareValue("done_o after ignored start", 32'(done_o), 32'd0);
			compareValue("busy_o after ignored start", 32'(busy_o), 32'd0);
			@(negedge clk);
		end

		// --------------------
		// random normal pairs
		// --------------------
		for (int i = 0; i < N_RAND; i++) begin
			opA = randomOperand();
			opB = randomOperand();
			model = expectedProduct(opA, opB);
			runMultiply(opA, opB, 0, res, flags);
			compareValue($sformatf("random %0d result", i), res, model[31:0]);
			compareValue($sformatf("random %0d flags", i), 32'(flags),
				32'({2'b00, model[32], 1'b0}));
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/fpMul32.sv */
/*
 * Top level of the binary32 multiply unit.
 * Pulse start_i while busy_o is low. done_o pulses 28 cycles after the
 * accepting edge, and result_o with the flags holds until the next done.
 */
`timescale 1ns/100ps
`default_nettype none

module fpMul32 (
	input wire logic clk,
	input wire logic rstN_i,
	input wire logic start_i,
	input wire logic [31:0] a_i,
	input wire logic [31:0] b_i,
	output logic busy_o,
	output logic done_o,
	output logic [31:0] result_o,
	output logic underflow_o,
	output logic overflow_o,
	output logic inexact_o,
	output logic invalid_o
);
	import fpMulPkg::*;

	logic cntLoad;
	logic [CNT_W-1:0] cntValue;
	logic cntZero;
	logic load;
	logic step;
	logic normCe;
	logic roundEn;
	fpXS xProd;
	logic coreUnder;
	fpSpecS spec;
	fpNS nVal;
	logic normUnder;
	logic normInexact;
	fp32U resultW;

	fpMulCtrl ctrl0 (
		.clk(clk), .rstN_i(rstN_i), .start_i(start_i), .cntZero_i(cntZero),
		.cntLoad_o(cntLoad), .cntValue_o(cntValue), .load_o(load), .step_o(step),
		.normCe_o(normCe), .roundEn_o(roundEn), .busy_o(busy_o), .done_o(done_o)
	);

	fpMulStepCounter cnt0 (
		.clk(clk), .rstN_i(rstN_i), .load_i(cntLoad), .value_i(cntValue), .zero_o(cntZero)
	);

	fpMulCore core0 (
		.clk(clk), .rstN_i(rstN_i), .load_i(load), .step_i(step), .a_i(a_i), .b_i(b_i),
		.x_o(xProd), .under_o(coreUnder), .spec_o(spec)
	);

	fpNormalize32 norm0 (
		.clk(clk), .ce_i(normCe), .x_i(xProd), .under_i(coreUnder),
		.n_o(nVal), .under_o(normUnder), .inexact_o(normInexact)
	);

	fpRound32 round0 (
		.clk(clk), .rstN_i(rstN_i), .en_i(roundEn), .n_i(nVal), .under_i(normUnder),
		.inexact_i(normInexact), .spec_i(spec), .result_o(resultW),
		.underflow_o(underflow_o), .overflow_o(overflow_o), .inexact_o(inexact_o),
		.invalid_o(invalid_o)
	);

	assign result_o = resultW.bits;

endmodule

`default_nettype wire

/* source/fpRound32.sv */
/*
 * Round-to-nearest-even stage and result register.
 * Rounds the normalized value, saturates to infinity on overflow and
 * lets a special-case outcome replace the arithmetic result. Result and
 * flags are registered on en_i and hold until the next enable.
 */
`timescale 1ns/100ps
`default_nettype none

module fpRound32 (
	input wire logic clk,
	input wire logic rstN_i,
	input wire logic en_i,
	input wire fpMulPkg::fpNS n_i,
	input wire logic under_i,
	input wire logic inexact_i,
	input wire fpMulPkg::fpSpecS spec_i,
	output fpMulPkg::fp32U result_o,
	output logic underflow_o,
	output logic overflow_o,
	output logic inexact_o,
	output logic invalid_o
);
	import fpMulPkg::*;

	logic roundUp;
	// carry, whole bit and fraction after rounding
	logic [FP_SIG_W+1:0] sigSum;
	logic [FP_EXP_W:0] expAdj;
	logic ovf;
	fp32U resNext;
	logic underNext;
	logic ovfNext;
	logic inexactNext;
	logic invalidNext;

	always_comb begin
		// ties go up only when the kept lsb is odd
		roundUp = n_i.guard & (n_i.round | n_i.sticky | n_i.frac[0]);
		sigSum = {1'b0, n_i.whole, n_i.frac} + {{(FP_SIG_W+1){1'b0}}, roundUp};
		// a carry out means 2.0, otherwise a clear whole bit is a denormal
		if (sigSum[FP_SIG_W+1]) begin
			expAdj = {1'b0, n_i.exp} + 1'b1;
		end else if (sigSum[FP_SIG_W]) begin
			expAdj = {1'b0, n_i.exp};
		end else begin
			expAdj = '0;
		end
		ovf = (expAdj >= {1'b0, FP_EXP_MAX});

		resNext.bits = '0;
		underNext = 1'b0;
		ovfNext = 1'b0;
		inexactNext = 1'b0;
		invalidNext = 1'b0;
		if (spec_i.valid) begin
			resNext = spec_i.word;
			invalidNext = spec_i.invalid;
		end else if (ovf) begin
			resNext.f.sign = n_i.sign;
			resNext.f.exp = FP_EXP_MAX;
			ovfNext = 1'b1;
			inexactNext = 1'b1;
		end else begin
			resNext.f.sign = n_i.sign;
			resNext.f.exp = expAdj[FP_EXP_W-1:0];
			resNext.f.frac = sigSum[FP_SIG_W+1] ? sigSum[FP_SIG_W:1] : sigSum[FP_SIG_W-1:0];
			inexactNext = inexact_i;
			// tininess is judged before rounding
			underNext = under_i & inexact_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			result_o <= '0;
			underflow_o <= 1'b0;
			overflow_o <= 1'b0;
			inexact_o <= 1'b0;
			invalid_o <= 1'b0;
		end else if (en_i) begin
			result_o <= resNext;
			underflow_o <= underNext;
			overflow_o <= ovfNext;
			inexact_o <= inexactNext;
			invalid_o <= invalidNext;
		end
	end

endmodule

`default_nettype wire

/* source/fpNormalize32.sv */
/*
 * Two-cycle normalizer from the expanded product to one whole bit.
 * The first stage drops a whole bit, folds the tail into sticky and
 * counts leading zeros. The second stage shifts left, or right into the
 * denormal range when the exponent underflowed. Output follows the input
 * by two ce_i edges. A denormal leaves with exponent one and whole bit zero.
 */
`timescale 1ns/100ps
`default_nettype none

module fpNormalize32 (
	input wire logic clk,
	input wire logic ce_i,
	input wire fpMulPkg::fpXS x_i,
	input wire logic under_i,
	output fpMulPkg::fpNS n_o,
	output logic under_o,
	output logic inexact_o
);
	import fpMulPkg::*;

	logic incExp0;
	logic [FP_MAN_W-1:0] manAdj0;
	logic signed [FP_XEXP_W-1:0] exp0;
	// whole bit, fraction, guard, round and sticky
	logic [FP_SIG_W+3:0] mo0;
	logic [FP_SH_W-1:0] lz0;
	logic inf0;
	logic under0;

	logic sign1;
	logic signed [FP_XEXP_W-1:0] exp1;
	logic [FP_SIG_W+3:0] mo1;
	logic [FP_SH_W-1:0] lz1;
	logic inf1;
	logic under1;

	logic signed [FP_XEXP_W-1:0] rDist2;
	logic signed [FP_XEXP_W-1:0] expM1;
	logic [FP_SH_W-1:0] rAmt2;
	logic [FP_SH_W-1:0] lAmt2;
	logic [2*FP_SIG_W+7:0] wideR2;
	logic [FP_SIG_W+3:0] moR2;
	logic [FP_SIG_W+3:0] moL2;
	logic [FP_SIG_W+3:0] mo2;
	logic [FP_EXP_W-1:0] exp2;

	// --------------------
	// stage 1
	// --------------------
	// a set top bit means the product is in [2,4) and the exponent grows
	assign incExp0 = x_i.man[FP_MAN_W-1];
	assign manAdj0 = incExp0 ? x_i.man : (x_i.man << 1);
	assign exp0 = x_i.exp + FP_XEXP_W'(incExp0);
	assign mo0 = {manAdj0[FP_MAN_W-1 -: FP_SIG_W+3], |manAdj0[FP_MAN_W-FP_SIG_W-4:0]};
	// the increment can pull a zero sum back into the normal range
	assign under0 = under_i && (exp0[FP_XEXP_W-1] || exp0 == '0);
	assign inf0 = !under0 && (exp0 >= $signed({2'b00, FP_EXP_MAX}));

	// a zero significand counts as all zeros
	always_comb begin
		logic found;
		found = 1'b0;
		lz0 = '0;
		for (int i = FP_SIG_W + 3; i >= 0; i--) begin
			if (!found) begin
				if (mo0[i]) begin
					found = 1'b1;
				end else begin
					lz0 = lz0 + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ce_i) begin
			sign1 <= x_i.sign;
			exp1 <= exp0;
			mo1 <= mo0;
			lz1 <= lz0;
			inf1 <= inf0;
			under1 <= under0;
		end
	end

	// --------------------
	// stage 2
	// --------------------
	// shifts of the full width or more leave only the sticky bit
	assign rDist2 = $signed(FP_XEXP_W'(1)) - exp1;
	assign rAmt2 = (rDist2 > $signed(FP_XEXP_W'(FP_SIG_W + 4))) ?
		FP_SH_W'(FP_SIG_W + 4) : FP_SH_W'(rDist2);
	assign wideR2 = {mo1, (FP_SIG_W+4)'(0)} >> rAmt2;
	assign moR2 = {wideR2[2*FP_SIG_W+7 -: FP_SIG_W+3], |wideR2[FP_SIG_W+4:0]};

	// the exponent may not drop below one, the denormal scale
	assign expM1 = exp1 - $signed(FP_XEXP_W'(1));
	assign lAmt2 = ($signed(FP_XEXP_W'(lz1)) < expM1) ? lz1 : FP_SH_W'(expM1);
	assign moL2 = {mo1[FP_SIG_W+3:1] << lAmt2, mo1[0]};

	always_comb begin
		if (inf1) begin
			// left as is, the rounder turns it into infinity
			exp2 = FP_EXP_MAX;
			mo2 = mo1;
		end else if (under1) begin
			exp2 = FP_EXP_W'(1);
			mo2 = moR2;
		end else begin
			exp2 = FP_EXP_W'(exp1 - $signed(FP_XEXP_W'(lAmt2)));
			mo2 = moL2;
		end
	end

	always_ff @(posedge clk) begin
		if (ce_i) begin
			n_o.sign <= sign1;
			n_o.exp <= exp2;
			{n_o.whole, n_o.frac, n_o.guard, n_o.round, n_o.sticky} <= mo2;
			under_o <= under1;
			inexact_o <= |mo2[2:0];
		end
	end

endmodule

`default_nettype wire

/* source/fpMulCore.sv */
/*
 * Operand front end and significand multiplier.
 * On load both words are classified, the product sign and biased exponent
 * are registered and the special-case outcome is formed. Each step then
 * runs one shift-and-add iteration, so the full product is ready
 * MUL_STEPS steps after load.
 */
`timescale 1ns/100ps
`default_nettype none

module fpMulCore (
	input wire logic clk,
	input wire logic rstN_i,
	input wire logic load_i,
	input wire logic step_i,
	input wire logic [31:0] a_i,
	input wire logic [31:0] b_i,
	output fpMulPkg::fpXS x_o,
	output logic under_o,
	output fpMulPkg::fpSpecS spec_o
);
	import fpMulPkg::*;

	fp32U opA;
	fp32U opB;
	fpClassE classA;
	fpClassE classB;
	logic signNext;
	logic signed [FP_XEXP_W-1:0] expSum;
	fpSpecS specNext;

	logic signR;
	logic signed [FP_XEXP_W-1:0] expR;
	fpSpecS specR;
	logic [FP_SIG_W:0] mcand;
	logic [FP_MAN_W-1:0] prod;
	logic [FP_SIG_W+1:0] partSum;

	// a zero exponent is taken as zero, so denormal inputs flush
	function automatic fpClassE classify(input fp32U w);
		if (w.f.exp == '0) begin
			return FP_ZERO;
		end else if (w.f.exp != FP_EXP_MAX) begin
			return FP_NORMAL;
		end else if (w.f.frac == '0) begin
			return FP_INF;
		end
		return FP_NAN;
	endfunction

	assign opA = a_i;
	assign opB = b_i;
	assign classA = classify(opA);
	assign classB = classify(opB);
	assign signNext = opA.f.sign ^ opB.f.sign;
	assign expSum = FP_XEXP_W'(opA.f.exp) + FP_XEXP_W'(opB.f.exp) - FP_XEXP_W'(FP_BIAS);

	// --------------------
	// special results
	// --------------------
	always_comb begin
		specNext.valid = (classA != FP_NORMAL) || (classB != FP_NORMAL);
		specNext.invalid = 1'b0;
		specNext.word.bits = '0;
		if (((classA == FP_NAN || classA == FP_INF) && classB == FP_ZERO) ||
		    ((classB == FP_NAN || classB == FP_INF) && classA == FP_ZERO)) begin
			specNext.word.bits = FP_QNAN;
			specNext.invalid = 1'b1;
		end else if (classA == FP_NAN || classB == FP_NAN) begin
			specNext.word.bits = FP_QNAN;
		end else if (classA == FP_INF || classB == FP_INF) begin
			specNext.word.f.sign = signNext;
			specNext.word.f.exp = FP_EXP_MAX;
		end else begin
			// only a zero operand is left here
			specNext.word.f.sign = signNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			signR <= 1'b0;
			expR <= '0;
			specR <= '0;
		end else if (load_i) begin
			signR <= signNext;
			expR <= expSum;
			specR <= specNext;
		end
	end

	// --------------------
	// shift-and-add multiply
	// --------------------
	// the multiplier sits in the low half and leaves one bit per step
	// while the partial product grows into the high half
	assign partSum = {1'b0, prod[FP_MAN_W-1:FP_SIG_W+1]} + (prod[0] ? {1'b0, mcand} : '0);

	always_ff @(posedge clk) begin
		if (load_i) begin
			mcand <= {1'b1, opA.f.frac};
			prod <= FP_MAN_W'({1'b1, opB.f.frac});
		end else if (step_i) begin
			prod <= {partSum, prod[FP_SIG_W:1]};
		end
	end

	assign x_o.sign = signR;
	assign x_o.exp = expR;
	assign x_o.man = prod;
	// a biased sum at or below zero needs the right shift unless the
	// normalizer's exponent increment recovers it
	assign under_o = expR[FP_XEXP_W-1] || (expR == '0);
	assign spec_o = specR;

endmodule

`default_nettype wire

/* source/fpMulStepCounter.sv */
/*
 * Loadable down-counter shared by the multiply and normalize phases.
 * value_i is the phase length in cycles. zero_o is the terminal count
 * and is high in the last cycle of the phase.
 */
`timescale 1ns/100ps
`default_nettype none

module fpMulStepCounter (
	input wire logic clk,
	input wire logic rstN_i,
	input wire logic load_i,
	input wire logic [fpMulPkg::CNT_W-1:0] value_i,
	output logic zero_o
);
	import fpMulPkg::*;

	logic [CNT_W-1:0] count;

	// the load cycle is the first cycle of the phase, so one is taken off
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			count <= '0;
		end else if (load_i) begin
			count <= value_i - 1'b1;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// counting stops at zero, so the level holds until the next load
	assign zero_o = (count == '0);

endmodule

`default_nettype wire

/* source/fpMulCtrl.sv */
/*
 * Sequencer of the multiply unit.
 * A start strobe seen while idle loads the operands, then the FSM runs the
 * multiply steps, holds the normalizer enable and fires the round strobe.
 * Phase lengths come from the shared step counter. busy is high from the
 * accept edge until done, and done is a single-cycle pulse.
 */
`timescale 1ns/100ps
`default_nettype none

module fpMulCtrl (
	input wire logic clk,
	input wire logic rstN_i,
	input wire logic start_i,
	input wire logic cntZero_i,
	output logic cntLoad_o,
	output logic [fpMulPkg::CNT_W-1:0] cntValue_o,
	output logic load_o,
	output logic step_o,
	output logic normCe_o,
	output logic roundEn_o,
	output logic busy_o,
	output logic done_o
);
	import fpMulPkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_MULTIPLY,
		ST_NORMALIZE,
		ST_ROUND,
		ST_FINISH
	} stateE;

	stateE state;
	stateE stateNext;

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			state <= ST_IDLE;
		end else begin
			state <= stateNext;
		end
	end

	// the counter is loaded only from idle and at the end of the multiply
	assign cntValue_o = (state == ST_IDLE) ? CNT_W'(MUL_STEPS) : CNT_W'(NORM_LAT);

	always_comb begin
		stateNext = state;
		cntLoad_o = 1'b0;
		load_o = 1'b0;
		step_o = 1'b0;
		normCe_o = 1'b0;
		roundEn_o = 1'b0;
		case (state)
			ST_IDLE: begin
				// operands are captured on the accepting edge itself
				if (start_i) begin
					load_o = 1'b1;
					cntLoad_o = 1'b1;
					stateNext = ST_MULTIPLY;
				end
			end
			ST_MULTIPLY: begin
				step_o = 1'b1;
				// terminal count marks the last multiply step
				if (cntZero_i) begin
					cntLoad_o = 1'b1;
					stateNext = ST_NORMALIZE;
				end
			end
			ST_NORMALIZE: begin
				normCe_o = 1'b1;
				if (cntZero_i) begin
					stateNext = ST_ROUND;
				end
			end
			ST_ROUND: begin
				roundEn_o = 1'b1;
				stateNext = ST_FINISH;
			end
			default: begin
				stateNext = ST_IDLE;
			end
		endcase
	end

	assign busy_o = (state != ST_IDLE);
	assign done_o = (state == ST_FINISH);

endmodule

`default_nettype wire

/* source/fpMulPkg.sv */
/*
 * Shared definitions for the binary32 multiply unit.
 * Holds the format widths, the operand word decoded as raw bits and as
 * fields, and the structs passed from the core to the normalizer and on
 * to the rounder. Each RTL module imports what it needs from here.
 */
`default_nettype none

package fpMulPkg;

	// --------------------
	// format widths
	// --------------------
	localparam int FP_EXP_W = 8;
	localparam int FP_SIG_W = 23;
	localparam int FP_BIAS = 127;
	// product significand, two whole bits followed by 46 fraction bits
	localparam int FP_MAN_W = 48;
	// signed intermediate exponent, wide enough for the underflow range
	localparam int FP_XEXP_W = 10;
	// width of the leading-zero count and of the normalizer shift amounts
	localparam int FP_SH_W = 5;
	localparam logic [FP_EXP_W-1:0] FP_EXP_MAX = '1;
	// default quiet NaN, positive with only the quiet bit set
	localparam logic [31:0] FP_QNAN = 32'h7FC0_0000;

	// --------------------
	// sequencing
	// --------------------
	localparam int MUL_STEPS = 24;
	localparam int NORM_LAT = 2;
	localparam int CNT_W = 5;

	typedef struct packed {
		logic sign;
		logic [FP_EXP_W-1:0] exp;
		logic [FP_SIG_W-1:0] frac;
	} fp32S;

	// one binary32 word, seen either as raw bits or as its fields
	typedef union packed {
		logic [31:0] bits;
		fp32S f;
	} fp32U;

	typedef enum logic [1:0] {
		FP_NORMAL,
		FP_ZERO,
		FP_INF,
		FP_NAN
	} fpClassE;

	// expanded product as it leaves the multiplier
	typedef struct packed {
		logic sign;
		logic signed [FP_XEXP_W-1:0] exp;
		logic [FP_MAN_W-1:0] man;
	} fpXS;

	// normalized value with one whole bit and the three rounding bits
	typedef struct packed {
		logic sign;
		logic [FP_EXP_W-1:0] exp;
		logic whole;
		logic [FP_SIG_W-1:0] frac;
		logic guard;
		logic round;
		logic sticky;
	} fpNS;

	// outcome for NaN, infinity and zero operands
	typedef struct packed {
		logic valid;
		fp32U word;
		logic invalid;
	} fpSpecS;

endpackage

`default_nettype wire
